// File: dfe_adapt_ctrl.f
logic/dfe_adapt_pkg.sv
logic/channel_sweep_if.sv
logic/sync_chain.sv
logic/rate_debounce.sv
logic/ltssm_monitor.sv
logic/channel_indexer.sv
logic/adapt_sequencer.sv
logic/dfe_adapt_ctrl.sv
dv/dfe_adapt_ctrl_tb.sv

// File: dv/dfe_adapt_ctrl_tb.sv
/* Link adaptation controller testbench
   Sequencer responder, job model, random holds and durations, watchdog */
module dfe_adapt_ctrl_tb;

  localparam int num_channels  = 4;
  localparam int ctle_wait     = 40;
  localparam int dfe_wait      = 30;
  localparam int num_tests     = 6;
  localparam int watchdog_time = num_tests * (ctle_wait + dfe_wait + 200) * 20;
  localparam int idle_span     = 24;

  // Job operation codes as seen by the responder
  localparam int op_gen12   = 1;
  localparam int op_gen3    = 2;
  localparam int op_restore = 3;
  localparam int op_ctle    = 4;
  localparam int op_dfe     = 5;

  logic       clock;
  logic       reset_sync;
  logic       ltssm_detect_quiet;
  logic       ltssm_detect_active;
  logic       ltssm_rcvr_equalization;
  logic [1:0] pcie_rate_sw;
  logic       sequencer_running;
  logic       rcfg_lock;
  logic       cmd_go;
  logic       cmd_gen12;
  logic       cmd_gen3;
  logic       cmd_restore_modeb;
  logic       cmd_phase2_ctle;
  logic       cmd_phase2_dfe;
  logic [1:0] channel;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  bit slow_jobs   = 1'b0;

  // Model state
  int model_rate;
  bit modeb_armed;
  bit phase2_armed;

  // Expected and observed jobs
  int exp_op[$];
  int exp_lane[$];
  int got_op[$];
  int got_lane[$];
  int got_start[$];
  int got_end[$];

  dfe_adapt_ctrl #(
    .num_channels     (num_channels),
    .channel_bits     (2),
    .hip_mode         (0),
    .ctle_wait_cycles (ctle_wait),
    .dfe_wait_cycles  (dfe_wait)
  ) u_dut (
    .clock                   (clock),
    .reset_sync              (reset_sync),
    .ltssm_detect_quiet      (ltssm_detect_quiet),
    .ltssm_detect_active     (ltssm_detect_active),
    .ltssm_rcvr_equalization (ltssm_rcvr_equalization),
    .pcie_rate_sw            (pcie_rate_sw),
    .sequencer_running       (sequencer_running),
    .rcfg_lock               (rcfg_lock),
    .cmd_go                  (cmd_go),
    .cmd_gen12               (cmd_gen12),
    .cmd_gen3                (cmd_gen3),
    .cmd_restore_modeb       (cmd_restore_modeb),
    .cmd_phase2_ctle         (cmd_phase2_ctle),
    .cmd_phase2_dfe          (cmd_phase2_dfe),
    .channel                 (channel)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(string name, int actual, int expected);
    check_count++;
    if (actual != expected) begin
      error_count++;
      $display("Fail at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  function automatic int pick_between(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // Any rate code except the current one
  function automatic int pick_other_rate(int current);
    return (current + 1 + int'($urandom % 3)) % 4;
  endfunction

  // With hip_mode 0 only code 2 selects Gen3
  function automatic int rate_op(int code);
    return (code == 2) ? op_gen3 : op_gen12;
  endfunction

  // Cycles end 2 units after the rising edge
  task automatic step(int n);
    repeat (n) @(posedge clock);
    #2;
  endtask

  task automatic expect_sweep(int op);
    for (int lane = 0; lane < num_channels; lane++) begin
      exp_op.push_back(op);
      exp_lane.push_back(lane);
    end
  endtask

  task automatic compare_jobs;
    check_value("job_count", got_op.size(), exp_op.size());
    for (int i = 0; i < exp_op.size() && i < got_op.size(); i++) begin
      check_value("job_op", got_op[i], exp_op[i]);
      check_value("job_lane", got_lane[i], exp_lane[i]);
    end
    exp_op.delete();
    exp_lane.delete();
    got_op.delete();
    got_lane.delete();
    got_start.delete();
    got_end.delete();
  endtask

  // Lock and sequencer both quiet for a full span
  task automatic wait_idle;
    int low_cycles;
    int waited;
    low_cycles = 0;
    waited     = 0;
    while (low_cycles < idle_span && waited < 2000) begin
      step(1);
      waited++;
      if (rcfg_lock || sequencer_running) low_cycles = 0;
      else low_cycles++;
    end
    if (low_cycles < idle_span) begin
      error_count++;
      $display("Error at time %0t: controller stayed busy past the wait limit", $time);
    end
  endtask

  task automatic wait_busy;
    int waited;
    waited = 0;
    while (!rcfg_lock && waited < 100) begin
      step(1);
      waited++;
    end
    if (!rcfg_lock) begin
      error_count++;
      $display("Error at time %0t: controller never started a sweep", $time);
    end
  endtask

  task automatic check_quiet(int cycles);
    repeat (cycles) begin
      step(1);
      check_value("lock_go_strobes", {rcfg_lock, cmd_go, cmd_gen12, cmd_gen3,
                  cmd_restore_modeb, cmd_phase2_ctle, cmd_phase2_dfe}, 0);
      check_value("channel", channel, 0);
    end
  endtask

  ////////////////////
  // Sequencer responder
  ////////////////////

  initial begin : responder
    int op;
    int strobes;
    int len;
    sequencer_running = 1'b0;
    forever begin
      @(posedge clock);
      #2;
      if (!reset_sync && cmd_go && !sequencer_running) begin
        strobes = cmd_gen12 + cmd_gen3 + cmd_restore_modeb + cmd_phase2_ctle + cmd_phase2_dfe;
        check_value("strobe_count", strobes, 1);
        check_value("rcfg_lock", rcfg_lock, 1);
        op = cmd_gen12 ? op_gen12 : cmd_gen3 ? op_gen3 :
             cmd_restore_modeb ? op_restore : cmd_phase2_ctle ? op_ctle : op_dfe;
        got_op.push_back(op);
        got_lane.push_back(int'(channel));
        got_start.push_back(cycle_count);
        len = slow_jobs ? 6 : pick_between(1, 6);
        sequencer_running = 1'b1;
        repeat (len) @(posedge clock);
        #2;
        // Falling edge completes the lane
        sequencer_running = 1'b0;
        got_end.push_back(cycle_count);
      end
    end
  end

  ////////////////////
  // Test scenarios
  ////////////////////

  task automatic rate_test;
    int next_rate;
    for (int i = 0; i < 3; i++) begin
      next_rate = pick_other_rate(model_rate);
      pcie_rate_sw = 2'(next_rate);
      expect_sweep(rate_op(next_rate));
      model_rate = next_rate;
      wait_idle();
      compare_jobs();
    end
  endtask

  // Short glitch on the request is filtered out
  task automatic excursion_test;
    pcie_rate_sw = 2'(pick_other_rate(model_rate));
    step(pick_between(1, 7));
    pcie_rate_sw = 2'(model_rate);
    wait_idle();
    compare_jobs();
  endtask

  task automatic detect_test;
    int hold;
    ltssm_detect_quiet = 1'b1;
    if (modeb_armed) expect_sweep(op_restore);
    modeb_armed = 1'b0;
    wait_idle();
    step(pick_between(1, 8));
    compare_jobs();
    // Brief exit from detect, too short to re-arm
    for (int pass = 0; pass < 2; pass++) begin
      ltssm_detect_quiet = 1'b0;
      hold = (pass == 0) ? pick_between(1, 5) : pick_between(10, 20);
      step(hold);
      if (hold >= 8) modeb_armed = 1'b1;
      ltssm_detect_quiet = 1'b1;
      if (modeb_armed) expect_sweep(op_restore);
      modeb_armed = 1'b0;
      wait_idle();
      compare_jobs();
    end
    ltssm_detect_quiet = 1'b0;
    step(pick_between(10, 16));
    modeb_armed = 1'b1;
  endtask

  task automatic equalization_test;
    ltssm_rcvr_equalization = 1'b1;
    if (phase2_armed) begin
      expect_sweep(op_restore);
      expect_sweep(op_ctle);
      expect_sweep(op_dfe);
    end
    phase2_armed = 1'b0;
    // Settle waits keep the lock high
    wait_idle();
    step(pick_between(5, 20));
    if (got_op.size() >= 3 * num_channels) begin
      check_value("ctle_gap_ok", int'(got_start[4] - got_end[3] >= ctle_wait), 1);
      check_value("dfe_gap_ok", int'(got_start[8] - got_end[7] >= dfe_wait), 1);
    end
    compare_jobs();
    ltssm_rcvr_equalization = 1'b0;
    step(12);
    // Detect stayed low the whole time
    phase2_armed = 1'b1;
    modeb_armed  = 1'b1;
  endtask

  // Both requests wait behind a long sweep, rate goes first
  task automatic priority_test;
    int first_rate;
    int second_rate;
    slow_jobs  = 1'b1;
    first_rate = pick_other_rate(model_rate);
    pcie_rate_sw = 2'(first_rate);
    expect_sweep(rate_op(first_rate));
    wait_busy();
    second_rate = pick_other_rate(first_rate);
    pcie_rate_sw       = 2'(second_rate);
    ltssm_detect_quiet = 1'b1;
    expect_sweep(rate_op(second_rate));
    if (modeb_armed) expect_sweep(op_restore);
    modeb_armed = 1'b0;
    model_rate  = second_rate;
    wait_idle();
    compare_jobs();
    slow_jobs          = 1'b0;
    ltssm_detect_quiet = 1'b0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    void'($urandom(38032));
    reset_sync              = 1'b1;
    ltssm_detect_quiet      = 1'b0;
    ltssm_detect_active     = 1'b0;
    ltssm_rcvr_equalization = 1'b0;
    pcie_rate_sw            = 2'd0;
    repeat (2) @(posedge clock);
    #2;
    reset_sync = 1'b0;
    check_quiet(30);
    // Detect and equalization have been low since reset
    model_rate   = 0;
    modeb_armed  = 1'b1;
    phase2_armed = 1'b1;
    rate_test();
    excursion_test();
    detect_test();
    equalization_test();
    priority_test();
    step(10);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_time);
    $display("Timeout: run did not finish within %0d time units", watchdog_time);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: logic/dfe_adapt_ctrl.sv
/* PCIe receiver link adaptation controller
   Drives the external reconfiguration sequencer lane by lane */
module dfe_adapt_ctrl #(
  parameter int num_channels     = 8,
  parameter int channel_bits     = 3,
  parameter int hip_mode         = 0,
  parameter int ctle_wait_cycles = 1200000,
  parameter int dfe_wait_cycles  = 1000000
) (
  input  logic                      clock,
  input  logic                      reset_sync,
  input  logic                      ltssm_detect_quiet,
  input  logic                      ltssm_detect_active,
  input  logic                      ltssm_rcvr_equalization,
  input  dfe_adapt_pkg::pcie_rate_t pcie_rate_sw,
  input  logic                      sequencer_running,
  output logic                      rcfg_lock,
  output logic                      cmd_go,
  output logic                      cmd_gen12,
  output logic                      cmd_gen3,
  output logic                      cmd_restore_modeb,
  output logic                      cmd_phase2_ctle,
  output logic                      cmd_phase2_dfe,
  output logic [channel_bits-1:0]   channel
);
  import dfe_adapt_pkg::*;

  pcie_rate_t    pcie_rate;
  ltssm_status_t ltssm;
  ltssm_status_t ltssm_sync;
  logic          skew_timeout;

  channel_sweep_if #(.channel_bits(channel_bits)) sweep ();

  // Bundle the raw LTSSM levels
  assign ltssm.rcvr_equalization = ltssm_rcvr_equalization;
  assign ltssm.detect_active     = ltssm_detect_active;
  assign ltssm.detect_quiet      = ltssm_detect_quiet;
  assign channel                 = sweep.channel;

  rate_debounce u_rate_debounce (
    .clock        (clock),
    .reset_sync   (reset_sync),
    .pcie_rate_sw (pcie_rate_sw),
    .pcie_rate    (pcie_rate)
  );

  ltssm_monitor u_ltssm_monitor (
    .clock        (clock),
    .reset_sync   (reset_sync),
    .ltssm        (ltssm),
    .ltssm_sync   (ltssm_sync),
    .skew_timeout (skew_timeout)
  );

  adapt_sequencer #(
    .hip_mode         (hip_mode),
    .ctle_wait_cycles (ctle_wait_cycles),
    .dfe_wait_cycles  (dfe_wait_cycles)
  ) u_adapt_sequencer (
    .clock             (clock),
    .reset_sync        (reset_sync),
    .pcie_rate         (pcie_rate),
    .ltssm_sync        (ltssm_sync),
    .skew_timeout      (skew_timeout),
    .sweep             (sweep.controller),
    .rcfg_lock         (rcfg_lock),
    .cmd_go            (cmd_go),
    .cmd_gen12         (cmd_gen12),
    .cmd_gen3          (cmd_gen3),
    .cmd_restore_modeb (cmd_restore_modeb),
    .cmd_phase2_ctle   (cmd_phase2_ctle),
    .cmd_phase2_dfe    (cmd_phase2_dfe)
  );

  channel_indexer #(
    .num_channels (num_channels),
    .channel_bits (channel_bits)
  ) u_channel_indexer (
    .clock             (clock),
    .reset_sync        (reset_sync),
    .sequencer_running (sequencer_running),
    .sweep             (sweep.indexer)
  );

endmodule

// File: logic/adapt_sequencer.sv
/* Adaptation FSM
   Chooses the reconfiguration operation, times the settle waits, drives strobes */
module adapt_sequencer #(
  parameter int hip_mode         = 0,
  parameter int ctle_wait_cycles = 1200000,
  parameter int dfe_wait_cycles  = 1000000
) (
  input  logic                         clock,
  input  logic                         reset_sync,
  input  dfe_adapt_pkg::pcie_rate_t    pcie_rate,
  input  dfe_adapt_pkg::ltssm_status_t ltssm_sync,
  input  logic                         skew_timeout,
  channel_sweep_if.controller          sweep,
  output logic                         rcfg_lock,
  output logic                         cmd_go,
  output logic                         cmd_gen12,
  output logic                         cmd_gen3,
  output logic                         cmd_restore_modeb,
  output logic                         cmd_phase2_ctle,
  output logic                         cmd_phase2_dfe
);
  import dfe_adapt_pkg::*;

  localparam timer_t     ctle_limit = timer_t'(ctle_wait_cycles);
  localparam timer_t     dfe_limit  = timer_t'(dfe_wait_cycles);
  localparam pcie_rate_t gen3_code  = (hip_mode != 0) ? RATE_GEN3_HIP : RATE_GEN3_STD;

  adapt_state_t state;
  pcie_rate_t   current_rate;
  timer_t       timer;
  logic         modeb_pending;
  logic         phase2_pending;
  logic         rate_change;
  logic         restore_request;
  logic         executing;

  assign rate_change = (current_rate != pcie_rate);

  // Mode B restore is due on detect quiet or on a fresh phase 2 request
  assign restore_request = (ltssm_sync.detect_quiet && modeb_pending) ||
                           (ltssm_sync.rcvr_equalization && phase2_pending);

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      state          <= idle;
      current_rate   <= '0;
      timer          <= '0;
      modeb_pending  <= 1'b1;
      phase2_pending <= 1'b0;
    end else begin
      case (state)
        idle: begin
          current_rate <= pcie_rate;
          timer        <= '0;
          // Re-arm once detect has been left long enough
          if (skew_timeout) begin
            modeb_pending <= 1'b1;
          end
          // Equalization dropped, so phase 2 may run again
          if (!ltssm_sync.rcvr_equalization) begin
            phase2_pending <= 1'b1;
          end
          // Rate switch has priority over a restore
          if (rate_change) begin
            state <= execute_rate_sw;
          end else if (restore_request) begin
            state <= restore_modeb;
          end
        end

        execute_rate_sw: begin
          if (sweep.sweep_done) begin
            state <= idle;
          end
        end

        restore_modeb: begin
          modeb_pending <= 1'b0;
          // Phase 2 follows only while equalization is still requested
          if (sweep.sweep_done) begin
            state <= ltssm_sync.rcvr_equalization ? timeout_ctle : idle;
          end
        end

        timeout_ctle: begin
          // Wait lasts ctle_limit + 1 cycles
          if (timer == ctle_limit) begin
            timer <= '0;
            state <= execute_ctle;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        execute_ctle: begin
          if (sweep.sweep_done) begin
            state <= timeout_dfe;
          end
        end

        timeout_dfe: begin
          if (timer == dfe_limit) begin
            timer <= '0;
            state <= execute_dfe;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        execute_dfe: begin
          // Phase 2 done for this equalization request
          phase2_pending <= 1'b0;
          if (sweep.sweep_done) begin
            state <= idle;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  ////////////////////
  // Command strobes
  ////////////////////

  // Sequencer runs in every execute state
  assign executing = (state inside {execute_rate_sw, restore_modeb, execute_ctle, execute_dfe});

  assign sweep.sweep_active = executing;
  assign cmd_go             = executing;
  assign rcfg_lock          = (state != idle);

  // Gen3 decode depends on soft or hard IP code
  assign cmd_gen3          = (state == execute_rate_sw) && (current_rate == gen3_code);
  assign cmd_gen12         = (state == execute_rate_sw) && (current_rate != gen3_code);
  assign cmd_restore_modeb = (state == restore_modeb);
  assign cmd_phase2_ctle   = (state == execute_ctle);
  assign cmd_phase2_dfe    = (state == execute_dfe);

  // Sequencer must never see two operations at once
  assert property (@(posedge clock) disable iff (reset_sync)
    $onehot0({cmd_gen12, cmd_gen3, cmd_restore_modeb, cmd_phase2_ctle, cmd_phase2_dfe}));

  // Transceiver stays locked from the user while a job is requested
  assert property (@(posedge clock) disable iff (reset_sync)
    cmd_go |-> rcfg_lock);

endmodule

// File: logic/channel_indexer.sv
/* Lane indexer
   Steps the lane on each sequencer completion and flags the sweep end */
module channel_indexer #(
  parameter int num_channels = 8,
  parameter int channel_bits = 3
) (
  input  logic               clock,
  input  logic               reset_sync,
  input  logic               sequencer_running,
  channel_sweep_if.indexer   sweep
);

  localparam logic [channel_bits-1:0] last_channel = channel_bits'(num_channels - 1);

  logic                    running_q;
  logic [channel_bits-1:0] channel_q;

  // Falling edge of the running flag, only inside a sweep
  assign sweep.channel_done = running_q & ~sequencer_running & sweep.sweep_active;
  assign sweep.sweep_done   = sweep.channel_done && (channel_q == last_channel);
  assign sweep.channel      = channel_q;

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      running_q <= 1'b0;
      channel_q <= '0;
    end else begin
      running_q <= sequencer_running;
      if (!sweep.sweep_active) begin
        // Every sweep starts at lane 0
        channel_q <= '0;
      end else if (sweep.channel_done && (channel_q != last_channel)) begin
        channel_q <= channel_q + 1'b1;
      end
    end
  end

  // Lane index never addresses a missing lane
  assert property (@(posedge clock) disable iff (reset_sync)
    channel_q < num_channels);

endmodule

// File: logic/ltssm_monitor.sv
/* LTSSM status monitor
   Synchronizes the status levels and times how long detect has been left */
module ltssm_monitor (
  input  logic                         clock,
  input  logic                         reset_sync,
  input  dfe_adapt_pkg::ltssm_status_t ltssm,
  output dfe_adapt_pkg::ltssm_status_t ltssm_sync,
  output logic                         skew_timeout
);
  import dfe_adapt_pkg::*;

  localparam int cnt_bits = $clog2(STABLE_CYCLES);

  logic [cnt_bits-1:0] skew_cnt;
  logic                in_detect;

  ////////////////////
  // Three-flop sync
  ////////////////////

  sync_chain #(
    .data_t (ltssm_status_t),
    .depth  (3)
  ) u_ltssm_sync (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (ltssm),
    .q          (ltssm_sync)
  );

  ////////////////////
  // Skew counter
  ////////////////////

  // Either detect substate holds the counter at zero
  assign in_detect    = ltssm_sync.detect_quiet | ltssm_sync.detect_active;
  assign skew_timeout = (skew_cnt == cnt_bits'(STABLE_CYCLES - 1));

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      skew_cnt <= '0;
    end else if (in_detect) begin
      skew_cnt <= '0;
    end else if (!skew_timeout) begin
      // Saturates once the window has elapsed
      skew_cnt <= skew_cnt + 1'b1;
    end
  end

endmodule

// File: logic/rate_debounce.sv
/* Rate request filter
   Synchronizes the software rate and accepts a new value once it is stable */
module rate_debounce (
  input  logic                      clock,
  input  logic                      reset_sync,
  input  dfe_adapt_pkg::pcie_rate_t pcie_rate_sw,
  output dfe_adapt_pkg::pcie_rate_t pcie_rate
);
  import dfe_adapt_pkg::*;

  localparam int cnt_bits = $clog2(STABLE_CYCLES);

  pcie_rate_t          rate_sync;
  logic [cnt_bits-1:0] stable_cnt;
  logic                rate_differs;

  ////////////////////
  // Two-flop sync
  ////////////////////

  sync_chain #(
    .data_t (pcie_rate_t),
    .depth  (2)
  ) u_rate_sync (
    .clock      (clock),
    .reset_sync (reset_sync),
    .d          (pcie_rate_sw),
    .q          (rate_sync)
  );

  ////////////////////
  // Change filter
  ////////////////////

  assign rate_differs = (rate_sync != pcie_rate);

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      stable_cnt <= '0;
      pcie_rate  <= '0;
    end else if (rate_differs) begin
      // Count while the request disagrees, accept on the last count
      if (stable_cnt != cnt_bits'(STABLE_CYCLES - 1)) begin
        stable_cnt <= stable_cnt + 1'b1;
      end else begin
        pcie_rate <= rate_sync;
      end
    end else begin
      // Any agreement restarts the window
      stable_cnt <= '0;
    end
  end

endmodule

// File: logic/sync_chain.sv
/* Multi-flop synchronizer for any packed payload */
module sync_chain #(
  parameter type data_t = logic,
  parameter int  depth  = 2
) (
  input  logic  clock,
  input  logic  reset_sync,
  input  data_t d,
  output data_t q
);

  // Stage 0 samples the asynchronous input
  data_t stages [depth];

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      for (int i = 0; i < depth; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= d;
      // Shift toward the output
      for (int i = 1; i < depth; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign q = stages[depth-1];

endmodule

// File: logic/channel_sweep_if.sv
/* Lane sweep link between the adaptation FSM and the lane indexer */
interface channel_sweep_if #(
  parameter int channel_bits = 3
);

  // FSM is in one of the execute states
  logic                    sweep_active;
  // Sequencer finished the current lane
  logic                    channel_done;
  // Last lane finished
  logic                    sweep_done;
  // Lane the sequencer works on
  logic [channel_bits-1:0] channel;

  modport controller (
    input  sweep_done,
    output sweep_active
  );

  modport indexer (
    input  sweep_active,
    output channel_done,
    output sweep_done,
    output channel
  );

endinterface

// File: logic/dfe_adapt_pkg.sv
/* Link adaptation shared definitions
   Rate codes, LTSSM status payload, FSM encoding and settle timer type */
package dfe_adapt_pkg;

  ////////////////////
  // Rate request
  ////////////////////

  // Software rate code
  typedef logic [1:0] pcie_rate_t;

  // Gen3 code differs between soft IP and hard IP use
  localparam pcie_rate_t RATE_GEN3_STD = 2'd2;
  localparam pcie_rate_t RATE_GEN3_HIP = 2'd3;

  // Rate change filter length, also the detect skew window
  localparam int STABLE_CYCLES = 8;

  ////////////////////
  // LTSSM status
  ////////////////////

  typedef struct packed {
    logic rcvr_equalization;
    logic detect_active;
    logic detect_quiet;
  } ltssm_status_t;

  ////////////////////
  // Adaptation FSM
  ////////////////////

  typedef enum logic [2:0] {
    idle,
    execute_rate_sw,
    restore_modeb,
    timeout_ctle,
    execute_ctle,
    timeout_dfe,
    execute_dfe
  } adapt_state_t;

  // Settle counter, covers 1.2M cycles
  typedef logic [20:0] timer_t;

endpackage
